/* design/seq_config.svh */
`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

// condition word width. Input xN sits at bit N-1.
`define SEQ_COND_W 20

// microoperation word width. Output yN sits at bit N-1.
`define SEQ_UOP_W 42

// control state encoding.
`define SEQ_STATE_W 6
`define SEQ_RESET_STATE 6'd1

`endif

/* design/seq_pkg.sv */
`include "seq_config.svh"

package seq_pkg;

	// one condition word as sampled from the datapath.
	typedef logic [`SEQ_COND_W-1:0] cond_t;

	// one microoperation word. A set bit makes that microoperation active.
	typedef logic [`SEQ_UOP_W-1:0] uop_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// control states keep the numbering of the microprogram table.
	typedef enum logic [`SEQ_STATE_W-1:0] {
		st_01 = `SEQ_RESET_STATE,
		st_02 = 6'd2,
		st_03 = 6'd3,
		st_04 = 6'd4,
		st_05 = 6'd5,
		st_06 = 6'd6,
		st_07 = 6'd7,
		st_08 = 6'd8,
		st_09 = 6'd9,
		st_10 = 6'd10,
		st_11 = 6'd11,
		st_12 = 6'd12,
		st_13 = 6'd13,
		st_14 = 6'd14,
		st_15 = 6'd15,
		st_16 = 6'd16,
		st_17 = 6'd17,
		st_18 = 6'd18,
		st_19 = 6'd19,
		st_20 = 6'd20,
		st_21 = 6'd21,
		st_22 = 6'd22,
		st_23 = 6'd23,
		st_24 = 6'd24,
		st_25 = 6'd25,
		st_26 = 6'd26,
		st_27 = 6'd27,
		st_28 = 6'd28,
		st_29 = 6'd29,
		st_30 = 6'd30,
		st_32 = 6'd32,
		st_33 = 6'd33,
		st_29x = 6'd34 // the one successor of state 29.
	} ctl_state_e;

endpackage

/* design/cond_capture.sv */
`timescale 1ns/1ps

module cond_capture (
	input  logic           rst,
	input  logic           clk,
	input  logic           req,
	input  seq_pkg::cond_t cond,
	input  logic           ack,
	output logic           step,
	output seq_pkg::cond_t cond_q
);

	typedef enum logic {
		cap_idle,
		cap_busy
	} cap_state_e;

	cap_state_e state;
	logic accept;

	// a new request counts only once the previous ack has gone away.
	assign accept = (state == cap_idle) && req && !ack;

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state <= cap_idle;
			step <= 1'b0;
		end
		else
		begin
			step <= accept; // one pulse per transaction.
			case (state)
				cap_idle:
					if (accept)
						state <= cap_busy;
				cap_busy:
					if (ack && !req)
						state <= cap_idle; // ack clears at this same edge.
				default:
					state <= cap_idle;
			endcase
		end
	end

	// the datapath holds cond while req is high, so one sample is enough.
	always_ff @(posedge rst)
	begin
		if (accept)
			cond_q <= cond;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// a transaction stays open until ack falls, so no step may overlap an ack.
	assert property (@(posedge rst) disable iff (!clk)
		step |-> !ack)
		else $error("cond_capture: step issued while a transaction was open.");

endmodule

/* design/ctl_sequencer.sv */
`timescale 1ns/1ps
`include "seq_config.svh"

module ctl_sequencer (
	input  logic           rst,
	input  logic           clk,
	input  logic           step,
	input  seq_pkg::cond_t cond_q,
	output logic           uop_valid,
	output seq_pkg::uop_t  uop_next
);

	seq_pkg::ctl_state_e state;
	seq_pkg::ctl_state_e nxt;
	seq_pkg::ctl_state_e join_nxt;
	logic [`SEQ_COND_W:1] x; // x[n] is condition input xn.
	logic [`SEQ_UOP_W:1] y; // y[n] is microoperation yn.
	logic [`SEQ_UOP_W:1] join_y;
	logic exit_y37;
	logic x13_pass;

	assign x = cond_q;

	// leaving through state 13 raises y37 on x18 with x10 or x11.
	assign exit_y37 = x[18] && (x[10] || x[11]);

	// with x12 clear and x13 set, states 12 and 27 pass on this test.
	assign x13_pass = x[15] ? (x[16] || x[9]) : (x[16] ? x[8] : x[7]);

	// ~~~~~~~~~~~~~~~~~~~~
	// the join decode shared by states 27, 29x and 33.
	always_comb
	begin
		join_y = '0;
		join_nxt = seq_pkg::st_28;
		if (x[12] && x[16])
		begin
			{join_y[9], join_y[16], join_y[25]} = '1;
			join_nxt = seq_pkg::st_13;
		end
		else if (!x[12] && x[13])
		begin
			join_y[27] = 1'b1;
			join_nxt = seq_pkg::st_13;
		end
		else if (!x[12] && x[14])
		begin
			join_y[14:11] = '1;
			join_nxt = seq_pkg::st_14;
		end
		else
			join_y[5:2] = '1;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		y = '0;

		// straight-line states have a fixed successor.
		case (state)
			seq_pkg::st_02: nxt = seq_pkg::st_06;
			seq_pkg::st_03: nxt = seq_pkg::st_07;
			seq_pkg::st_05: nxt = seq_pkg::st_08;
			seq_pkg::st_06: nxt = seq_pkg::st_09;
			seq_pkg::st_07: nxt = seq_pkg::st_10;
			seq_pkg::st_08: nxt = seq_pkg::st_11;
			seq_pkg::st_11: nxt = seq_pkg::st_12;
			seq_pkg::st_14, seq_pkg::st_17, seq_pkg::st_23, seq_pkg::st_26:
				nxt = seq_pkg::st_13;
			seq_pkg::st_15: nxt = seq_pkg::st_20;
			seq_pkg::st_16: nxt = seq_pkg::st_21;
			seq_pkg::st_18: nxt = seq_pkg::st_22;
			seq_pkg::st_19: nxt = seq_pkg::st_14;
			seq_pkg::st_20: nxt = seq_pkg::st_23;
			seq_pkg::st_21: nxt = seq_pkg::st_24;
			seq_pkg::st_24: nxt = seq_pkg::st_27;
			seq_pkg::st_25: nxt = seq_pkg::st_28;
			seq_pkg::st_29: nxt = seq_pkg::st_29x;
			seq_pkg::st_30: nxt = seq_pkg::st_32;
			seq_pkg::st_32: nxt = seq_pkg::st_33;
			default: nxt = seq_pkg::st_01; // branch states override this below.
		endcase

		case (state)
			seq_pkg::st_01:
			begin
				if (x[6] && x[5] && x[19] && x[20])
					{y[6], y[10], y[15], y[25]} = '1;
				else if (x[6] && x[5] && x[19])
				begin
					{y[1], y[5:3], y[34]} = '1;
					nxt = seq_pkg::st_02;
				end
				else if (x[6] && x[5] && x[20])
					y[6] = 1'b1;
				else if (x[6] && x[5])
				begin
					{y[4], y[6], y[10], y[16], y[26], y[33]} = '1;
					nxt = seq_pkg::st_03;
				end
				else if (x[6] && x[4])
				begin
					{y[7], y[8], y[15], y[16], y[25]} = '1;
					nxt = seq_pkg::st_04;
				end
				else if (x[6])
				begin
					{y[7], y[23]} = '1;
					nxt = seq_pkg::st_05;
				end
			end
			seq_pkg::st_02: {y[6], y[10], y[16], y[19], y[26], y[42]} = '1;
			seq_pkg::st_03, seq_pkg::st_06: y[39] = 1'b1;
			seq_pkg::st_04: {y[10], y[15], y[16], y[27], y[32], y[41]} = '1;
			seq_pkg::st_05, seq_pkg::st_11, seq_pkg::st_15, seq_pkg::st_16,
			seq_pkg::st_20, seq_pkg::st_23, seq_pkg::st_24:
				y[28] = 1'b1;
			seq_pkg::st_07: {y[5], y[8], y[34]} = '1;
			seq_pkg::st_08: {y[7], y[38]} = '1;
			seq_pkg::st_09: {y[2], y[8], y[33], y[42]} = '1;
			seq_pkg::st_10: y[10] = 1'b1;
			seq_pkg::st_12:
			begin
				nxt = seq_pkg::st_13;
				if (x[12] && (x[14] || x[15]) && !x[13])
				begin
					{y[14:11], y[9]} = '1;
					nxt = seq_pkg::st_14;
				end
				else if (x[12] && x[14])
					{y[32], y[31]} = {x[16], !x[16]};
				else if (x[12] && x[15])
				begin
					if (x[16])
						{y[9], y[29], y[30]} = '1;
					else
						{y[6], y[7], y[8], y[17], y[40]} = '1;
				end
				else if (x[12] && x[13])
				begin
					if (x[16] ? x[11] : x[10])
					begin
						y[28] = 1'b1;
						nxt = seq_pkg::st_15;
					end
					else
					begin
						y[37] = exit_y37;
						nxt = seq_pkg::st_01;
					end
				end
				else if (x[3])
				begin
					{y[7], y[21], y[33]} = '1;
					nxt = seq_pkg::st_16;
				end
				else if (x[12] && x[16] && x[1])
				begin
					{y[16], y[26]} = '1;
					nxt = seq_pkg::st_17;
				end
				else if (x[12] && x[16])
					{y[6], y[7], y[9], y[17], y[24]} = '1;
				else if (x[12])
				begin
					y[18] = 1'b1;
					nxt = seq_pkg::st_18;
				end
				else if (x[13] && x13_pass)
					{y[16], y[27]} = '1;
				else if (x[13])
				begin
					y[37] = exit_y37;
					nxt = seq_pkg::st_01;
				end
				else if (x[14])
				begin
					y[14:11] = '1;
					{y[6], y[7], y[16]} = {x[1], x[1], !x[1]};
					nxt = seq_pkg::st_14;
				end
				else
				begin
					y[5:4] = '1;
					{y[3:2], y[7:6]} = {4{x[1]}};
					nxt = seq_pkg::st_19;
				end
			end
			seq_pkg::st_13: y[37] = exit_y37;
			seq_pkg::st_14: {y[6], y[8], y[17]} = '1;
			seq_pkg::st_17: {y[8], y[9], y[16], y[25]} = '1;
			seq_pkg::st_18: y[5:4] = '1;
			seq_pkg::st_19: y[14:9] = '1;
			seq_pkg::st_21: {y[7], y[22], y[34]} = '1;
			seq_pkg::st_22:
			begin
				y[22:19] = {4{x[1]}};
				{y[9], y[18]} = {2{!x[1]}};
				nxt = x[1] ? seq_pkg::st_25 : seq_pkg::st_26;
			end
			seq_pkg::st_25: y[5:2] = '1;
			seq_pkg::st_26: y[17] = 1'b1;
			seq_pkg::st_27:
			begin
				nxt = seq_pkg::st_13;
				if (!x[12] && x[13] && !x13_pass)
				begin
					y[37] = exit_y37;
					nxt = seq_pkg::st_01;
				end
				else if (x[2] && !x[12] && x[13])
					{y[15], y[27]} = '1;
				else if (x[2] && !x[12] && x[14])
				begin
					y[15:11] = '1;
					nxt = seq_pkg::st_14;
				end
				else if (x[2] && !(x[12] && x[16]))
				begin
					{y[1], y[5:3], y[19], y[20], y[34]} = '1;
					nxt = seq_pkg::st_28;
				end
				else if (x[1])
				begin
					y[26] = 1'b1;
					nxt = seq_pkg::st_29;
				end
				else if (!x[17])
				begin
					y[5:4] = '1;
					nxt = seq_pkg::st_30;
				end
				else
				begin
					y = join_y;
					nxt = join_nxt;
				end
			end
			seq_pkg::st_28:
			begin
				y[9] = 1'b1;
				y[18] = x[12];
				y[14:10] = {5{!x[12]}};
				nxt = x[12] ? seq_pkg::st_26 : seq_pkg::st_14;
			end
			seq_pkg::st_29: {y[22:19], y[33], y[34]} = '1;
			seq_pkg::st_30: {y[35], y[36]} = '1;
			seq_pkg::st_32: {y[3:2], y[22:19]} = '1;
			seq_pkg::st_29x, seq_pkg::st_33:
			begin
				if (state == seq_pkg::st_33 || x[17])
				begin
					y = join_y;
					nxt = join_nxt;
				end
				else
				begin
					y[5:4] = '1;
					nxt = seq_pkg::st_30;
				end
			end
			default: y = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state <= seq_pkg::st_01;
			uop_valid <= 1'b0;
		end
		else
		begin
			uop_valid <= step;
			if (step)
				state <= nxt; // the sequencer only moves on a captured word.
		end
	end

	always_ff @(posedge rst)
	begin
		if (step)
			uop_next <= y;
	end

	assert property (@(posedge rst) disable iff (!clk)
		state inside {[seq_pkg::st_01 : seq_pkg::st_30], seq_pkg::st_32,
			seq_pkg::st_33, seq_pkg::st_29x})
		else $error("ctl_sequencer: illegal state %0d.", state);

	// step is a single pulse, so its word is flagged for one cycle only.
	assert property (@(posedge rst) disable iff (!clk) step |=> uop_valid ##1 !uop_valid)
		else $error("ctl_sequencer: uop_valid is not a one-cycle pulse after step.");

endmodule

/* design/uop_issue.sv */
`timescale 1ns/1ps

module uop_issue (
	input  logic          rst,
	input  logic          clk,
	input  logic          uop_valid,
	input  seq_pkg::uop_t uop_next,
	input  logic          req,
	output logic          ack,
	output seq_pkg::uop_t uop
);

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			ack <= 1'b0;
			uop <= '0;
		end
		else if (uop_valid)
		begin
			ack <= 1'b1;
			uop <= uop_next;
		end
		else if (!req)
			ack <= 1'b0; // the datapath has taken the word.
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// ack answers a request that is still being held.
	assert property (@(posedge rst) disable iff (!clk) $rose(ack) |-> $past(req))
		else $error("uop_issue: ack raised without a pending req.");

	// the word must not move under an open acknowledge.
	assert property (@(posedge rst) disable iff (!clk) ack && $past(ack) |-> $stable(uop))
		else $error("uop_issue: uop changed while ack was high.");

endmodule

/* design/seq_top.sv */
`timescale 1ns/1ps

module seq_top (
	input  logic           rst,
	input  logic           clk,
	input  seq_pkg::cond_t cond,
	input  logic           req,
	output logic           ack,
	output seq_pkg::uop_t  uop
);

	logic step;
	seq_pkg::cond_t cond_q;
	logic uop_valid;
	seq_pkg::uop_t uop_next;

	// capture, sequence and issue, one stage per cycle.
	cond_capture u_cond_capture (
		.rst    (rst),
		.clk    (clk),
		.req    (req),
		.cond   (cond),
		.ack    (ack),
		.step   (step),
		.cond_q (cond_q)
	);

	ctl_sequencer u_ctl_sequencer (
		.rst       (rst),
		.clk       (clk),
		.step      (step),
		.cond_q    (cond_q),
		.uop_valid (uop_valid),
		.uop_next  (uop_next)
	);

	uop_issue u_uop_issue (
		.rst       (rst),
		.clk       (clk),
		.uop_valid (uop_valid),
		.uop_next  (uop_next),
		.req       (req),
		.ack       (ack),
		.uop       (uop)
	);

endmodule

/* tb/seq_tests.svh */
`ifndef SEQ_TESTS_SVH
`define SEQ_TESTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// bit n-1 of a word carries xn or yn.
function automatic seq_pkg::cond_t xbit(input int n);
	seq_pkg::cond_t c;
	c = '0;
	c[n-1] = 1'b1;
	return c;
endfunction

function automatic seq_pkg::uop_t ybit(input int n);
	seq_pkg::uop_t w;
	w = '0;
	w[n-1] = 1'b1;
	return w;
endfunction

// condition bits that the branch does not test are left random.
function automatic seq_pkg::cond_t cond_with(input seq_pkg::cond_t set_bits,
	input seq_pkg::cond_t clr_bits);
	logic [31:0] r;
	r = $urandom();
	return (r[$bits(seq_pkg::cond_t)-1:0] | set_bits) & ~clr_bits;
endfunction

function automatic seq_pkg::cond_t stay_cond();
	return cond_with(xbit(5) | xbit(6) | xbit(19) | xbit(20), '0);
endfunction

function automatic seq_pkg::uop_t stay_word();
	return ybit(6) | ybit(10) | ybit(15) | ybit(25); // state 1 loops on itself.
endfunction

// ~~~~~~~~~~~~~~~~~~~~
task automatic check_eq(input seq_pkg::uop_t expected, input seq_pkg::uop_t actual,
	input string what);
	if (expected !== actual)
	begin
		fail_count++;
		$display("Fail at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
		$display("tests failed");
		$fatal(1, "value mismatch at %0t ns", $time);
	end
endtask

task automatic report_stall(input string what);
	$display("handshake stalled at %0t ns, %s.", $time, what);
	$display("tests failed");
	$fatal(1, "handshake timeout");
endtask

task automatic wait_ack(input logic level);
	int n;
	n = 0;
	while (ack !== level && n < hs_timeout)
	begin
		@(negedge rst);
		n++;
	end
	if (ack !== level)
		report_stall(level ? "ack never rose" : "ack never fell");
endtask

// one four-phase transaction. The word is taken while ack is high.
task automatic do_step(input seq_pkg::cond_t c, output seq_pkg::uop_t word);
	@(negedge rst);
	cond = c;
	req = 1'b1;
	wait_ack(1'b1);
	word = uop;
	req = 1'b0;
	wait_ack(1'b0);
endtask

task automatic step_check(input seq_pkg::cond_t c, input seq_pkg::uop_t expected,
	input string what);
	seq_pkg::uop_t word;
	do_step(c, word);
	check_eq(expected, word, what);
endtask

// state 1 to state 12 through states 5, 8 and 11.
task automatic enter_state_12();
	step_check(cond_with(xbit(6), xbit(5) | xbit(4)), ybit(7) | ybit(23), "st_01 to st_05");
	step_check(cond_with('0, '0), ybit(28), "st_05 to st_08");
	step_check(cond_with('0, '0), ybit(7) | ybit(38), "st_08 to st_11");
	step_check(cond_with('0, '0), ybit(28), "st_11 to st_12");
endtask

// ~~~~~~~~~~~~~~~~~~~~
task automatic test_reset_idle();
	check_eq('0, seq_pkg::uop_t'(ack), "ack after reset");
	check_eq('0, uop, "uop after reset");
	step_check(stay_cond(), stay_word(), "first step in st_01");
	step_check(stay_cond(), stay_word(), "repeated step in st_01");
endtask

task automatic test_short_routine();
	step_check(cond_with(xbit(5) | xbit(6) | xbit(19), xbit(20)),
		ybit(1) | ybit(3) | ybit(4) | ybit(5) | ybit(34), "st_01 to st_02");
	step_check(cond_with('0, '0),
		ybit(6) | ybit(10) | ybit(16) | ybit(19) | ybit(26) | ybit(42), "st_02 to st_06");
	step_check(cond_with('0, '0), ybit(39), "st_06 to st_09");
	step_check(cond_with('0, '0), ybit(2) | ybit(8) | ybit(33) | ybit(42), "st_09 to st_01");
	step_check(stay_cond(), stay_word(), "back in st_01");
endtask

task automatic test_branch_12();
	enter_state_12();
	step_check(cond_with('0, xbit(1) | xbit(3) | xbit(12) | xbit(13) | xbit(14)),
		ybit(4) | ybit(5), "st_12 to st_19");
	step_check(cond_with('0, '0), ybit(9) | ybit(10) | ybit(11) | ybit(12) | ybit(13) | ybit(14),
		"st_19 to st_14");
	step_check(cond_with('0, '0), ybit(6) | ybit(8) | ybit(17), "st_14 to st_13");
	step_check(cond_with(xbit(10) | xbit(18), '0), ybit(37), "st_13 exit with y37");
endtask

task automatic test_clean_29();
	repeat (6)
	begin
		enter_state_12();
		step_check(cond_with(xbit(3), xbit(12)), ybit(7) | ybit(21) | ybit(33), "st_12 to st_16");
		step_check(cond_with('0, '0), ybit(28), "st_16 to st_21");
		step_check(cond_with('0, '0), ybit(7) | ybit(22) | ybit(34), "st_21 to st_24");
		step_check(cond_with('0, '0), ybit(28), "st_24 to st_27");
		step_check(cond_with(xbit(1) | xbit(2) | xbit(12) | xbit(16), '0), ybit(26),
			"st_27 to st_29");
		step_check(cond_with('0, '0),
			ybit(19) | ybit(20) | ybit(21) | ybit(22) | ybit(33) | ybit(34), "st_29 onward");
		step_check(cond_with(xbit(12) | xbit(16) | xbit(17), '0), ybit(9) | ybit(16) | ybit(25),
			"clean state after st_29");
		step_check(cond_with('0, xbit(18)), '0, "st_13 exit without y37");
	end
endtask

task automatic test_handshake();
	seq_pkg::uop_t held;
	repeat (5)
	begin
		@(negedge rst);
		check_eq('0, seq_pkg::uop_t'(ack), "ack while req is low");
	end
	// state 1 moves on to state 2 here, so a second step under the held req would show.
	cond = cond_with(xbit(5) | xbit(6) | xbit(19), xbit(20));
	req = 1'b1;
	wait_ack(1'b1);
	held = uop;
	check_eq(ybit(1) | ybit(3) | ybit(4) | ybit(5) | ybit(34), held, "word under held req");
	repeat (10)
	begin
		@(negedge rst);
		check_eq(1, seq_pkg::uop_t'(ack), "ack while req is held");
		check_eq(held, uop, "uop while req is held");
	end
	req = 1'b0;
	wait_ack(1'b0); // ack drops once req is seen low.
	step_check(cond_with('0, '0),
		ybit(6) | ybit(10) | ybit(16) | ybit(19) | ybit(26) | ybit(42), "st_02 after held req");
	step_check(cond_with('0, '0), ybit(39), "st_06 after held req");
	step_check(cond_with('0, '0), ybit(2) | ybit(8) | ybit(33) | ybit(42),
		"st_09 after held req");
endtask

task automatic test_mid_reset();
	@(negedge rst);
	cond = cond_with(xbit(5) | xbit(6) | xbit(19), xbit(20));
	req = 1'b1;
	wait_ack(1'b1);
	check_eq(ybit(1) | ybit(3) | ybit(4) | ybit(5) | ybit(34), uop,
		"st_01 to st_02 before reset");
	clk = 1'b0; // reset lands while ack is still high.
	req = 1'b0;
	repeat (2) @(negedge rst);
	check_eq('0, seq_pkg::uop_t'(ack), "ack under reset");
	check_eq('0, uop, "uop under reset");
	clk = 1'b1;
	step_check(stay_cond(), stay_word(), "st_01 after reset");
endtask

`endif

/* tb/tb_seq_top.sv */
`timescale 1ns/1ps

module tb_seq_top;

	logic rst; // clock.
	logic clk; // active-low reset.
	seq_pkg::cond_t cond;
	logic req;
	logic ack;
	seq_pkg::uop_t uop;
	int fail_count;

	// cycles allowed for each handshake edge.
	localparam int hs_timeout = 16;

	seq_top u_seq_top (
		.rst  (rst),
		.clk  (clk),
		.cond (cond),
		.req  (req),
		.ack  (ack),
		.uop  (uop)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	always #20 rst = ~rst; // 40 ns period.

	`include "seq_tests.svh"

	// ~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		rst = 1'b0;
		clk = 1'b0;
		cond = '0;
		req = 1'b0;
		fail_count = 0;
		void'($urandom(32'h6200a8ff));

		repeat (5) @(posedge rst);
		@(negedge rst);
		clk = 1'b1;

		test_reset_idle();
		test_short_routine();
		test_branch_12();
		test_clean_29();
		test_handshake();
		test_mid_reset();

		if (fail_count == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+design
+incdir+tb
design/seq_pkg.sv
design/cond_capture.sv
design/ctl_sequencer.sv
design/uop_issue.sv
design/seq_top.sv
tb/tb_seq_top.sv

/* Bender.yml */
package:
  name: seq_top

sources:
  - include_dirs:
      - design
    files:
      - design/seq_pkg.sv
      - design/cond_capture.sv
      - design/ctl_sequencer.sv
      - design/uop_issue.sv
      - design/seq_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_seq_top.sv
